// ==== aes_128.f ====
+incdir+.
aes_pkg.sv
aes_sub_word.sv
aes_key_expand.sv
aes_round.sv
aes_final_round.sv
aes_128_core.sv
tb_aes_128.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the AES-128 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_aes_128 -f aes_128.f -o sim_aes_128

out=$(./obj_dir/sim_aes_128)
printf '%s\n' "$out"

if grep -q "Everything OK" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== tb_aes_model.svh ====
// Reference AES-128 encryption model for the testbench, as a plain round loop

`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

`include "aes_defs.svh"

// SubBytes on all sixteen bytes
function automatic logic [127:0] sub_bytes(input logic [127:0] s);
    logic [127:0] r;
    for (int i = 0; i < 16; i++) begin
        r[127-8*i -: 8] = aes_pkg::sbox(s[127-8*i -: 8]);
    end
    return r;
endfunction

// Byte 4*c+row of the result comes from column c+row of the input
function automatic logic [127:0] shift_rows(input logic [127:0] s);
    logic [127:0] r;
    for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
            r[127-8*(4*c+row) -: 8] = s[127-8*(4*((c+row)%4)+row) -: 8];
        end
    end
    return r;
endfunction

function automatic aes_pkg::byte_t times_three(input aes_pkg::byte_t b);
    return aes_pkg::xtime(b) ^ b;
endfunction

// Fixed matrix {02 03 01 01} applied per column
function automatic logic [127:0] mix_columns(input logic [127:0] s);
    logic [127:0] r;
    aes_pkg::byte_t a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
        a0 = s[127-32*c -: 8];
        a1 = s[119-32*c -: 8];
        a2 = s[111-32*c -: 8];
        a3 = s[103-32*c -: 8];
        r[127-32*c -: 8] = aes_pkg::xtime(a0) ^ times_three(a1) ^ a2 ^ a3;
        r[119-32*c -: 8] = a0 ^ aes_pkg::xtime(a1) ^ times_three(a2) ^ a3;
        r[111-32*c -: 8] = a0 ^ a1 ^ aes_pkg::xtime(a2) ^ times_three(a3);
        r[103-32*c -: 8] = times_three(a0) ^ a1 ^ a2 ^ aes_pkg::xtime(a3);
    end
    return r;
endfunction

function automatic aes_pkg::block_t aes_encrypt(input aes_pkg::block_t pt,
                                                input aes_pkg::block_t key);
    aes_pkg::word_t w [0:4*(`AES_ROUNDS+1)-1];
    aes_pkg::word_t t;
    aes_pkg::byte_t rc;
    logic [127:0] k;
    logic [127:0] s;
    k  = key;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
        w[i] = k[127-32*i -: 32];
    end
    // Key expansion, words w[4] to w[43]
    for (int i = 4; i < 4*(`AES_ROUNDS+1); i++) begin
        t = w[i-1];
        if (i % 4 == 0) begin
            t = {t[23:0], t[31:24]};
            t = {aes_pkg::sbox(t[31:24]), aes_pkg::sbox(t[23:16]),
                 aes_pkg::sbox(t[15:8]), aes_pkg::sbox(t[7:0])};
            t[31:24] = t[31:24] ^ rc;
            rc = aes_pkg::xtime(rc);
        end
        w[i] = w[i-4] ^ t;
    end
    s = pt ^ {w[0], w[1], w[2], w[3]};
    for (int r = 1; r <= `AES_ROUNDS; r++) begin
        s = shift_rows(sub_bytes(s));
        if (r != `AES_ROUNDS) begin
            s = mix_columns(s);
        end
        s = s ^ {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
    return s;
endfunction

`endif

// ==== tb_aes_128.sv ====
// Testbench for the pipelined AES-128 core: clock, stimulus, scoreboard, checks, timeout

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module tb_aes_128;

    // Roughly eight times the 240 cycles of reset, stimulus and pipeline drain
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int RAND_COUNT     = 100;
    localparam int NUM_TESTS      = 5;

    typedef struct packed {
        aes_pkg::block_t pt;
        aes_pkg::block_t key;
        aes_pkg::block_t lit;
        logic            has_lit;
        int              test_id;
        int              due;
    } pending_t;

    logic            clk;
    aes_pkg::block_t block_in;
    aes_pkg::block_t key;
    aes_pkg::block_t block_out;

    pending_t pending [$];
    int       cycle = 0;
    int       seed = 37;
    int       checks = 0;
    int       errors = 0;
    int       cur_test = 1;
    int       tests_done = 0;
    int       remaining   [1:NUM_TESTS];
    int       test_errors [1:NUM_TESTS];
    string    test_names  [1:NUM_TESTS];

    `include "tb_aes_model.svh"

    aes_128_core i_dut (
        .clk       (clk),
        .block_in  (block_in),
        .key       (key),
        .block_out (block_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %032h expected %032h", $time, name, got, exp);
            errors++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic draw_block(output aes_pkg::block_t b);
        b.col0 = $random(seed);
        b.col1 = $random(seed);
        b.col2 = $random(seed);
        b.col3 = $random(seed);
    endtask

    // Drive one pair on a falling edge; the next rising edge samples it
    task automatic apply_pair(input aes_pkg::block_t pt_val, input aes_pkg::block_t key_val,
                              input logic [127:0] lit, input logic has_lit, input int test_id);
        pending_t e;
        @(negedge clk);
        block_in  = pt_val;
        key       = key_val;
        e.pt      = pt_val;
        e.key     = key_val;
        e.lit     = lit;
        e.has_lit = has_lit;
        e.test_id = test_id;
        e.due     = cycle + `AES_LATENCY;
        pending.push_back(e);
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    initial begin : compare
        pending_t        e;
        aes_pkg::block_t model;
        forever begin
            @(negedge clk);
            while (pending.size() > 0 && pending[0].due == cycle) begin
                e        = pending.pop_front();
                cur_test = e.test_id;
                model    = aes_encrypt(e.pt, e.key);
                if (e.has_lit) begin
                    check_value("reference", model, e.lit);
                    check_value("block_out", block_out, e.lit);
                end else begin
                    check_value("block_out", block_out, model);
                end
                remaining[cur_test]--;
                if (remaining[cur_test] == 0) begin
                    $display("test %0d (%s): %s, %0d mismatches", cur_test,
                             test_names[cur_test],
                             (test_errors[cur_test] == 0) ? "pass" : "FAIL",
                             test_errors[cur_test]);
                    tests_done++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout: results still outstanding after %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        aes_pkg::block_t pt;
        aes_pkg::block_t k;
        aes_pkg::block_t fixed_key;
        int failed_tests;
        block_in      = '0;
        key           = '0;
        failed_tests  = 0;
        test_names[1] = "FIPS-197 appendix B";
        test_names[2] = "FIPS-197 appendix C.1";
        test_names[3] = "all-zero block and key";
        test_names[4] = "random blocks, fixed key";
        test_names[5] = "random blocks, random keys";
        for (int i = 1; i <= NUM_TESTS; i++) begin
            remaining[i]   = (i <= 3) ? 1 : RAND_COUNT;
            test_errors[i] = 0;
        end
        // Inputs held at zero while the pipeline fills
        repeat (RESET_CYCLES) @(negedge clk);

        apply_pair(128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                   128'h3925841d02dc09fbdc118597196a0b32, 1'b1, 1);
        apply_pair(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f,
                   128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1, 2);
        apply_pair('0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1'b1, 3);

        draw_block(fixed_key);
        for (int i = 0; i < RAND_COUNT; i++) begin
            draw_block(pt);
            apply_pair(pt, fixed_key, '0, 1'b0, 4);
        end
        // Each block brings its own fresh key
        for (int i = 0; i < RAND_COUNT; i++) begin
            draw_block(pt);
            draw_block(k);
            apply_pair(pt, k, '0, 1'b0, 5);
        end
        @(negedge clk);
        block_in = '0;
        key      = '0;

        while (tests_done < NUM_TESTS) begin
            @(negedge clk);
        end
        for (int i = 1; i <= NUM_TESTS; i++) begin
            if (test_errors[i] != 0) begin
                failed_tests++;
            end
        end
        $display("%0d checks, %0d errors, %0d of %0d tests failed",
                 checks, errors, failed_tests, NUM_TESTS);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aes_128_core.sv ====
// Fully pipelined AES-128 encryption core: whitening register, ten rounds, key schedule

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module aes_128_core (
    input  wire             clk,
    input  wire aes_pkg::block_t block_in,
    input  wire aes_pkg::block_t key,
    output aes_pkg::block_t block_out
);

    localparam int LAST = `AES_ROUNDS - 1;

    // Round constants in key schedule order
    localparam aes_pkg::byte_t RCON_TABLE [0:`AES_ROUNDS-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    aes_pkg::block_t state_q;
    aes_pkg::block_t key_q;
    aes_pkg::block_t state_chain [0:LAST];
    aes_pkg::block_t key_chain   [0:LAST];
    aes_pkg::block_t round_keys  [0:LAST];

    // Initial AddRoundKey, key travels alongside its block
    always_ff @(posedge clk) begin
        state_q <= block_in ^ key;
        key_q   <= key;
    end

    assign state_chain[0] = state_q;
    assign key_chain[0]   = key_q;

    ////////////////////
    // Middle rounds
    ////////////////////

    for (genvar i = 0; i < LAST; i++) begin : g_round
        aes_key_expand #(
            .RCON (RCON_TABLE[i])
        ) i_key_expand (
            .clk       (clk),
            .key_in    (key_chain[i]),
            .key_next  (key_chain[i+1]),
            .round_key (round_keys[i])
        );

        aes_round i_round (
            .clk       (clk),
            .state_in  (state_chain[i]),
            .round_key (round_keys[i]),
            .state_out (state_chain[i+1])
        );
    end

    ////////////////////
    // Last round
    ////////////////////

    // No further key stage follows, so key_next stays open
    aes_key_expand #(
        .RCON (RCON_TABLE[LAST])
    ) i_key_expand_last (
        .clk       (clk),
        .key_in    (key_chain[LAST]),
        .key_next  (),
        .round_key (round_keys[LAST])
    );

    aes_final_round i_final_round (
        .clk       (clk),
        .state_in  (state_chain[LAST]),
        .round_key (round_keys[LAST]),
        .state_out (block_out)
    );

endmodule

`default_nettype wire

// ==== aes_final_round.sv ====
// Two-cycle AES last round: SubBytes, ShiftRows and key add, no MixColumns

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module aes_final_round (
    input  wire             clk,
    input  wire aes_pkg::block_t state_in,
    input  wire aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    localparam int COLS = `AES_BLOCK_W / `AES_WORD_W;
    localparam int ROWS = `AES_WORD_W / `AES_BYTE_W;

    aes_pkg::word_t  sub_q [0:COLS-1];
    aes_pkg::block_t out_d;

    // Registered substitution, one column per instance
    for (genvar c = 0; c < COLS; c++) begin : g_sub
        aes_sub_word i_sub_word (
            .clk      (clk),
            .word_in  (state_in[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W]),
            .word_out (sub_q[c])
        );
    end

    // Row r of output column j comes from column j+r
    always_comb begin : shift_add
        aes_pkg::word_t col;
        for (int j = 0; j < COLS; j++) begin
            for (int r = 0; r < ROWS; r++) begin
                col[`AES_WORD_W-1-`AES_BYTE_W*r -: `AES_BYTE_W] =
                    sub_q[(j + r) % COLS][`AES_WORD_W-1-`AES_BYTE_W*r -: `AES_BYTE_W];
            end
            out_d[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W] =
                col ^ round_key[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        state_out <= out_d;
    end

endmodule

`default_nettype wire

// ==== aes_round.sv ====
// One two-cycle AES middle round built from registered T-table lookups

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module aes_round (
    input  wire             clk,
    input  wire aes_pkg::block_t state_in,
    input  wire aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    localparam int COLS = `AES_BLOCK_W / `AES_WORD_W;
    localparam int ROWS = `AES_WORD_W / `AES_BYTE_W;

    // Indexed [column][row] of the source byte
    aes_pkg::word_t  tbl_d [0:COLS-1][0:ROWS-1];
    aes_pkg::word_t  tbl_q [0:COLS-1][0:ROWS-1];
    aes_pkg::block_t mix_d;

    ////////////////////
    // Lookup stage
    ////////////////////

    // T word {2s, s, s, 3s}, rotated right one byte per row
    always_comb begin : lookup
        aes_pkg::byte_t s;
        aes_pkg::byte_t s2;
        aes_pkg::word_t t0;
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) begin
                s  = aes_pkg::sbox(
                    state_in[`AES_BLOCK_W-1-`AES_WORD_W*c-`AES_BYTE_W*r -: `AES_BYTE_W]);
                s2 = aes_pkg::xtime(s);
                t0 = {s2, s, s, s2 ^ s};
                tbl_d[c][r] = (t0 >> (`AES_BYTE_W*r)) |
                              (t0 << (`AES_WORD_W - `AES_BYTE_W*r));
            end
        end
    end

    always_ff @(posedge clk) begin
        tbl_q <= tbl_d;
    end

    ////////////////////
    // Combine stage
    ////////////////////

    // ShiftRows picks row r from column j+r
    always_comb begin : mix
        aes_pkg::word_t col;
        for (int j = 0; j < COLS; j++) begin
            col = round_key[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W];
            for (int r = 0; r < ROWS; r++) begin
                col = col ^ tbl_q[(j + r) % COLS][r];
            end
            mix_d[`AES_BLOCK_W-1-`AES_WORD_W*j -: `AES_WORD_W] = col;
        end
    end

    always_ff @(posedge clk) begin
        state_out <= mix_d;
    end

endmodule

`default_nettype wire

// ==== aes_key_expand.sv ====
// One two-cycle stage of the AES-128 key schedule

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module aes_key_expand #(
    parameter aes_pkg::byte_t RCON = 8'h01
) (
    input  wire             clk,
    input  wire aes_pkg::block_t key_in,
    output aes_pkg::block_t key_next,
    output aes_pkg::block_t round_key
);

    aes_pkg::word_t  v0, v1, v2, v3;
    aes_pkg::block_t acc_q;
    aes_pkg::word_t  rot_w;
    aes_pkg::word_t  sub_w;

    ////////////////////
    // First cycle
    ////////////////////

    // Round constant into the top byte, then running XOR over the columns
    assign v0 = key_in.col0 ^ {RCON, {(`AES_WORD_W-`AES_BYTE_W){1'b0}}};
    assign v1 = v0 ^ key_in.col1;
    assign v2 = v1 ^ key_in.col2;
    assign v3 = v2 ^ key_in.col3;

    always_ff @(posedge clk) begin
        acc_q <= {v0, v1, v2, v3};
    end

    // RotWord of the last column, substituted alongside
    assign rot_w = {key_in.col3[`AES_WORD_W-`AES_BYTE_W-1:0],
                    key_in.col3[`AES_WORD_W-1 -: `AES_BYTE_W]};

    aes_sub_word i_sub_word (
        .clk      (clk),
        .word_in  (rot_w),
        .word_out (sub_w)
    );

    ////////////////////
    // Second cycle
    ////////////////////

    // Lines up with the lookup registers of the matching round
    assign round_key.col0 = acc_q.col0 ^ sub_w;
    assign round_key.col1 = acc_q.col1 ^ sub_w;
    assign round_key.col2 = acc_q.col2 ^ sub_w;
    assign round_key.col3 = acc_q.col3 ^ sub_w;

    // Next stage sees it two cycles after key_in
    always_ff @(posedge clk) begin
        key_next <= round_key;
    end

endmodule

`default_nettype wire

// ==== aes_sub_word.sv ====
// Registered S-box substitution of the four bytes of one column

`timescale 1ns/1ps
`default_nettype none

`include "aes_defs.svh"

module aes_sub_word (
    input  wire            clk,
    input  wire aes_pkg::word_t word_in,
    output aes_pkg::word_t word_out
);

    localparam int BYTES = `AES_WORD_W / `AES_BYTE_W;

    // One lookup per byte, all in the same cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES; i++) begin
            word_out[`AES_WORD_W-1-`AES_BYTE_W*i -: `AES_BYTE_W] <=
                aes_pkg::sbox(word_in[`AES_WORD_W-1-`AES_BYTE_W*i -: `AES_BYTE_W]);
        end
    end

endmodule

`default_nettype wire

// ==== aes_pkg.sv ====
// AES-128 package: byte, column and block types plus GF(2^8) byte functions

`default_nettype none

`include "aes_defs.svh"

package aes_pkg;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [`AES_BYTE_W-1:0] byte_t;
    typedef logic [`AES_WORD_W-1:0] word_t;

    // One state or key, col0 is the first column on the wire
    typedef struct packed {
        word_t col0;
        word_t col1;
        word_t col2;
        word_t col3;
    } block_t;

    ////////////////////
    // GF(2^8) arithmetic
    ////////////////////

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted;
        shifted = {b[`AES_BYTE_W-2:0], 1'b0};
        return b[`AES_BYTE_W-1] ? (shifted ^ 8'h1b) : shifted;
    endfunction

    // Shift-and-add product of two field elements
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t cur;
        acc = '0;
        cur = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ cur;
            end
            cur = xtime(cur);
        end
        return acc;
    endfunction

    // Inverse as a^254; zero falls out as zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        // Accumulates a^2 * a^4 * ... * a^128
        for (int i = 1; i < `AES_BYTE_W; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Field inverse then the affine map
    function automatic byte_t sbox(input byte_t b);
        byte_t inv;
        byte_t res;
        inv = gf_inv(b);
        res = inv;
        for (int i = 1; i <= 4; i++) begin
            res = res ^ byte_t'((inv << i) | (inv >> (`AES_BYTE_W - i)));
        end
        return res ^ `AES_SBOX_AFFINE;
    endfunction

endpackage

`default_nettype wire

// ==== aes_defs.svh ====
// AES-128 widths, round count, pipeline latencies and S-box affine constant

`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// Datapath widths
`define AES_BYTE_W      8
`define AES_WORD_W      32
`define AES_BLOCK_W     128

// Rounds and pipeline depth
`define AES_ROUNDS      10
`define AES_STAGE_LAT   2
`define AES_LATENCY     21

// Constant added after the field inverse in the S-box
`define AES_SBOX_AFFINE 8'h63

`endif
